/* verilog/mmioPkg.sv */
package mmioPkg;

  // bus geometry
  // data and address share one width
  localparam int wordBits = 32;

  typedef logic [wordBits-1:0] word_t;

  // device map, top page of the address space
  localparam word_t addrHex = 32'hFFFF_F000;
  localparam word_t addrLedr = 32'hFFFF_F020;
  localparam word_t addrKey = 32'hFFFF_F080;
  localparam word_t addrSw = 32'hFFFF_F090;

  // input ports put their status register one word above the data
  localparam word_t ctrlOffset = 32'd4;

  // LED bank
  localparam int ledBits = 10;

  typedef logic [ledBits-1:0] ledData_t;

  // six digits, one nibble each
  localparam int hexDigits = 6;
  localparam int hexDataBits = hexDigits * 4;
  localparam int segBits = 7;

  // one digit, active low
  // segment a in bit 0 up to segment g in bit 6
  typedef logic [segBits-1:0] seg_t;

  typedef struct packed {
    seg_t digit5;
    seg_t digit4;
    seg_t digit3;
    seg_t digit2;
    seg_t digit1;
    seg_t digit0;
  } hexDisplay_t;

  // push buttons, already inverted so 1 means pressed
  typedef logic [3:0] keyData_t;

  // slide switches
  typedef logic [9:0] switchData_t;

  // one bus access from the master
  // we and re are single-cycle strobes, never both high
  typedef struct packed {
    word_t addr;
    word_t wrData;
    logic we;
    logic re;
  } ioReq_t;

  // status register layout
  // bit 2 is reserved and reads zero
  localparam int statReadyBit = 0;
  localparam int statOverrunBit = 1;
  localparam int statIeBit = 3;

  // about 12 ms of switch bounce at 50 MHz
  localparam int unsigned switchSettleCycles = 600000;

endpackage

/* verilog/ledPort.sv */
`timescale 1ns/1ps

module ledPort (
  input  logic                clk,
  input  logic                reset,
  input  mmioPkg::ioReq_t     req,
  output mmioPkg::word_t      rdData,
  output mmioPkg::ledData_t   ledr
);

  // single register at addrLedr
  logic ledSel;
  logic ledWrite;

  assign ledSel = (req.addr == mmioPkg::addrLedr);
  assign ledWrite = ledSel && req.we;

  // lamps follow the register directly
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledr <= '0;
    end else if (ledWrite) begin
      // upper bus bits are dropped
      ledr <= req.wrData[mmioPkg::ledBits-1:0];
    end
  end

  // readback, zero-extended
  // stays zero when another address is on the bus so the top can OR
  always_comb begin
    rdData = '0;
    if (ledSel) begin
      rdData[mmioPkg::ledBits-1:0] = ledr;
    end
  end

  ledRdIdle: assert property (@(posedge clk) disable iff (reset)
    (req.addr != mmioPkg::addrLedr) |-> (rdData == '0));

endmodule

/* verilog/hexPort.sv */
`timescale 1ns/1ps

module hexPort (
  input  logic                  clk,
  input  logic                  reset,
  input  mmioPkg::ioReq_t       req,
  output mmioPkg::word_t        rdData,
  output mmioPkg::hexDisplay_t  hex
);

  // one nibble to active-low segments, g..a
  function automatic mmioPkg::seg_t segOf(input logic [3:0] nibble);
    case (nibble)
      4'h0: segOf = 7'h40;
      4'h1: segOf = 7'h79;
      4'h2: segOf = 7'h24;
      4'h3: segOf = 7'h30;
      4'h4: segOf = 7'h19;
      4'h5: segOf = 7'h12;
      4'h6: segOf = 7'h02;
      4'h7: segOf = 7'h78;
      4'h8: segOf = 7'h00;
      4'h9: segOf = 7'h10;
      4'hA: segOf = 7'h08;
      // lower case b and d so they differ from 8 and 0
      4'hB: segOf = 7'h03;
      4'hC: segOf = 7'h46;
      4'hD: segOf = 7'h21;
      4'hE: segOf = 7'h06;
      default: segOf = 7'h0E;
    endcase
  endfunction

  // whole register to six digits, digit0 is the low nibble
  function automatic mmioPkg::hexDisplay_t decodeAll(
    input logic [mmioPkg::hexDataBits-1:0] value
  );
    mmioPkg::hexDisplay_t digits;
    digits.digit0 = segOf(value[3:0]);
    digits.digit1 = segOf(value[7:4]);
    digits.digit2 = segOf(value[11:8]);
    digits.digit3 = segOf(value[15:12]);
    digits.digit4 = segOf(value[19:16]);
    digits.digit5 = segOf(value[23:20]);
    return digits;
  endfunction

  logic hexSel;
  logic hexWrite;
  // value last written by the master
  logic [mmioPkg::hexDataBits-1:0] hexValue;
  mmioPkg::hexDisplay_t decoded;

  assign hexSel = (req.addr == mmioPkg::addrHex);
  assign hexWrite = hexSel && req.we;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hexValue <= '0;
    end else if (hexWrite) begin
      hexValue <= req.wrData[mmioPkg::hexDataBits-1:0];
    end
  end

  // decode is combinational from the register
  assign decoded = decodeAll(hexValue);

  // extra stage keeps the decode tree off the pad outputs
  // display lags the register by one cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex <= decodeAll('0);
    end else begin
      hex <= decoded;
    end
  end

  // readback of the raw 24 bits
  always_comb begin
    rdData = '0;
    if (hexSel) begin
      rdData[mmioPkg::hexDataBits-1:0] = hexValue;
    end
  end

  // display is the table image of the register one edge earlier
  hexFollowsValue: assert property (@(posedge clk) disable iff (reset)
    hex == decodeAll($past(hexValue)));

endmodule

/* verilog/inputPort.sv */
`timescale 1ns/1ps

module inputPort #(
  parameter type payloadT = logic,
  parameter mmioPkg::word_t base = '0,
  // zero leaves the input undebounced
  parameter int unsigned settleCycles = 0
) (
  input  logic             clk,
  input  logic             reset,
  input  mmioPkg::ioReq_t  req,
  output mmioPkg::word_t   rdData,
  input  payloadT          raw
);

  localparam int payloadBits = $bits(payloadT);
  // status register address
  localparam mmioPkg::word_t ctrlAddr = base + mmioPkg::ctrlOffset;

  // port data, after the optional settle filter
  payloadT data;
  // data as captured at the previous edge
  payloadT prev;
  logic dataChanged;

  logic dataSel;
  logic ctrlSel;
  logic dataRead;
  logic ctrlWrite;

  // status bits
  logic ready;
  logic overrun;
  logic ie;

  // address decode
  assign dataSel = (req.addr == base);
  assign ctrlSel = (req.addr == ctrlAddr);
  // read side effects only on the strobe
  assign dataRead = dataSel && req.re;
  assign ctrlWrite = ctrlSel && req.we;

  generate
    if (settleCycles == 0) begin : gDirect
      // keys go straight through
      assign data = raw;
    end else begin : gDebounce
      localparam int cntBits = (settleCycles > 1) ? $clog2(settleCycles) : 1;
      localparam logic [cntBits-1:0] lastCount = cntBits'(settleCycles - 1);

      // input one edge ago
      payloadT lastRaw;
      // last value that held long enough
      payloadT stable;
      // consecutive cycles with raw unchanged, saturating
      logic [cntBits-1:0] holdCount;
      logic settled;

      assign settled = (raw == lastRaw) && (holdCount == lastCount);

      always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
          holdCount <= '0;
        end else if (raw != lastRaw) begin
          // any movement restarts the window
          holdCount <= '0;
        end else if (holdCount != lastCount) begin
          holdCount <= holdCount + 1'b1;
        end
      end

      // while in reset the filter tracks the input
      // so the port leaves reset already settled
      always_ff @(posedge clk) begin
        lastRaw <= raw;
        if (reset || settled) begin
          stable <= raw;
        end
      end

      assign data = stable;
    end
  endgenerate

  // change detect against the captured copy
  always_ff @(posedge clk) begin
    prev <= data;
  end

  assign dataChanged = (data != prev);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ready <= 1'b0;
      overrun <= 1'b0;
      ie <= 1'b0;
    end else begin
      if (dataChanged) begin
        // unread value lost
        if (ready && !dataRead) begin
          overrun <= 1'b1;
        end else begin
          ready <= 1'b1;
        end
      end else if (dataRead) begin
        ready <= 1'b0;
      end
      // control write wins over a same-cycle overrun
      if (ctrlWrite) begin
        if (!req.wrData[mmioPkg::statOverrunBit]) begin
          overrun <= 1'b0;
        end
        ie <= req.wrData[mmioPkg::statIeBit];
      end
    end
  end

  // data zero-extended, status in its fixed bit slots
  always_comb begin
    rdData = '0;
    if (dataSel) begin
      rdData[payloadBits-1:0] = data;
    end else if (ctrlSel) begin
      rdData[mmioPkg::statReadyBit] = ready;
      rdData[mmioPkg::statOverrunBit] = overrun;
      rdData[mmioPkg::statIeBit] = ie;
    end
  end

  // overrun only ever follows a pending unread value
  overrunNeedsReady: assert property (@(posedge clk) disable iff (reset)
    $rose(overrun) |-> $past(ready));

  inputRdIdle: assert property (@(posedge clk) disable iff (reset)
    !(dataSel || ctrlSel) |-> (rdData == '0));

endmodule

/* verilog/mmioPeripherals.sv */
`timescale 1ns/1ps

module mmioPeripherals #(
  // switch debounce window in clock cycles
  parameter int unsigned settleCycles = mmioPkg::switchSettleCycles
) (
  input  logic                   clk,
  input  logic                   reset,
  input  mmioPkg::ioReq_t        req,
  output mmioPkg::word_t         rdData,
  // push buttons, low when pressed
  input  logic [3:0]             key,
  input  mmioPkg::switchData_t   sw,
  output mmioPkg::ledData_t      ledr,
  output mmioPkg::hexDisplay_t   hex
);

  // per-port read words, zero when not addressed
  mmioPkg::word_t ledRd;
  mmioPkg::word_t hexRd;
  mmioPkg::word_t keyRd;
  mmioPkg::word_t swRd;

  // buttons as seen by software, 1 means pressed
  mmioPkg::keyData_t keyDown;

  assign keyDown = ~key;

  // LED register
  ledPort u_ledPort (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .rdData (ledRd),
    .ledr   (ledr)
  );

  // seven-segment display register
  hexPort u_hexPort (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .rdData (hexRd),
    .hex    (hex)
  );

  // keys need no settle filter here
  inputPort #(
    .payloadT     (mmioPkg::keyData_t),
    .base         (mmioPkg::addrKey),
    .settleCycles (0)
  ) u_keyPort (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .rdData (keyRd),
    .raw    (keyDown)
  );

  // switches bounce, filter them
  inputPort #(
    .payloadT     (mmioPkg::switchData_t),
    .base         (mmioPkg::addrSw),
    .settleCycles (settleCycles)
  ) u_swPort (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .rdData (swRd),
    .raw    (sw)
  );

  // read mux
  // each port already returns zero when unselected
  assign rdData = ledRd | hexRd | keyRd | swRd;

  // address map has no overlap
  // so at most one port may drive the bus
  singleReader: assert property (@(posedge clk) disable iff (reset)
    $onehot0({|ledRd, |hexRd, |keyRd, |swRd}));

endmodule

/* tb/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
  parameter int periodNs = 100,
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic reset
);

  // free-running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* tb/mmioPeripheralsTb.sv */
`timescale 1ns/1ps

module mmioPeripheralsTb;

  // short switch window keeps the run small
  localparam int unsigned settleCycles = 8;
  // generous bound on total run length
  localparam int cycleLimit = 4000;
  localparam int pollLimit = 20;
  localparam mmioPkg::word_t keyCtrl = mmioPkg::addrKey + mmioPkg::ctrlOffset;
  localparam mmioPkg::word_t swCtrl = mmioPkg::addrSw + mmioPkg::ctrlOffset;

  // active-low patterns, index is the nibble
  localparam logic [6:0] segTable [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic clk;
  logic reset;
  mmioPkg::ioReq_t req;
  mmioPkg::word_t rdData;
  logic [3:0] key;
  mmioPkg::switchData_t sw;
  mmioPkg::ledData_t ledr;
  mmioPkg::hexDisplay_t hex;

  // expected register contents
  mmioPkg::ledData_t ledShadow;
  logic [mmioPkg::hexDataBits-1:0] hexShadow;

  int errorCount;
  int errorsAtStart;
  int testsRun;
  int testsFailed;
  int cycleCount;

  clockGen #(.periodNs(100), .resetCycles(10)) u_clockGen (
    .clk   (clk),
    .reset (reset)
  );

  mmioPeripherals #(.settleCycles(settleCycles)) u_mmioPeripherals (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .rdData (rdData),
    .key    (key),
    .sw     (sw),
    .ledr   (ledr),
    .hex    (hex)
  );

  function automatic void noteMismatch(input string msg);
    errorCount++;
    $display("Fail at %0t ns: %s", $time, msg);
  endfunction

  // six digits from the low 24 bits
  function automatic mmioPkg::hexDisplay_t expectedDisplay(input mmioPkg::word_t value);
    mmioPkg::hexDisplay_t digits;
    digits.digit0 = segTable[value[3:0]];
    digits.digit1 = segTable[value[7:4]];
    digits.digit2 = segTable[value[11:8]];
    digits.digit3 = segTable[value[15:12]];
    digits.digit4 = segTable[value[19:16]];
    digits.digit5 = segTable[value[23:20]];
    return digits;
  endfunction

  function automatic logic isMapped(input mmioPkg::word_t addr);
    return addr inside {mmioPkg::addrLedr, mmioPkg::addrHex, mmioPkg::addrKey,
                        keyCtrl, mmioPkg::addrSw, swCtrl};
  endfunction

  // LED lamps show a write on the next cycle
  ledTakesWrite: assert property (@(posedge clk) disable iff (reset)
    (req.we && req.addr == mmioPkg::addrLedr) |=>
      (ledr == $past(req.wrData[mmioPkg::ledBits-1:0])))
    else noteMismatch("ledr did not take the written value");

  // lamps move only on their own write
  ledHolds: assert property (@(posedge clk) disable iff (reset)
    !(req.we && req.addr == mmioPkg::addrLedr) |=> $stable(ledr))
    else noteMismatch("ledr changed without an LED write");

  // display two cycles behind the write strobe
  hexTakesWrite: assert property (@(posedge clk) disable iff (reset)
    (req.we && req.addr == mmioPkg::addrHex) |=> ##1
      (hex == expectedDisplay($past(req.wrData, 2))))
    else noteMismatch("hex digits do not match the written value");

  unmappedReadsZero: assert property (@(posedge clk) disable iff (reset)
    (req.re && !isMapped(req.addr)) |-> (rdData == '0))
    else noteMismatch("unmapped address returned nonzero data");

  // one strobe cycle per access
  task automatic writeBus(input mmioPkg::word_t addr, input mmioPkg::word_t data);
    @(posedge clk);
    req <= '{addr: addr, wrData: data, we: 1'b1, re: 1'b0};
    @(posedge clk);
    req.we <= 1'b0;
    if (addr == mmioPkg::addrLedr) begin
      ledShadow = data[mmioPkg::ledBits-1:0];
    end
    if (addr == mmioPkg::addrHex) begin
      hexShadow = data[mmioPkg::hexDataBits-1:0];
    end
  endtask

  // data sampled mid-cycle while re is high
  task automatic readBus(input mmioPkg::word_t addr, output mmioPkg::word_t value);
    @(posedge clk);
    req <= '{addr: addr, wrData: '0, we: 1'b0, re: 1'b1};
    @(negedge clk);
    value = rdData;
    @(posedge clk);
    req.re <= 1'b0;
  endtask

  task automatic checkRead(input mmioPkg::word_t addr, input mmioPkg::word_t expected,
                           input string what);
    mmioPkg::word_t value;
    readBus(addr, value);
    assert (value == expected)
      else noteMismatch($sformatf("%s read %h, expected %h", what, value, expected));
  endtask

  // down is 1 for a pressed key
  task automatic setKeys(input mmioPkg::keyData_t down);
    @(posedge clk);
    key <= ~down;
  endtask

  task automatic setSwitches(input mmioPkg::switchData_t value);
    @(posedge clk);
    sw <= value;
  endtask

  task automatic startTest();
    errorsAtStart = errorCount;
    testsRun++;
  endtask

  task automatic endTest(input string name);
    if (errorCount == errorsAtStart) begin
      $display("test %s: ok", name);
    end else begin
      testsFailed++;
      $display("test %s: %0d errors", name, errorCount - errorsAtStart);
    end
  endtask

  task automatic resetStateTest();
    startTest();
    @(negedge clk);
    assert (ledr == '0) else noteMismatch("ledr not zero after reset");
    assert (hex == expectedDisplay('0)) else noteMismatch("hex not all zero after reset");
    checkRead(keyCtrl, '0, "key status after reset");
    checkRead(swCtrl, '0, "switch status after reset");
    endTest("reset state");
  endtask

  task automatic ledWriteTest();
    startTest();
    repeat (20) begin
      writeBus(mmioPkg::addrLedr, $urandom);
      checkRead(mmioPkg::addrLedr, mmioPkg::word_t'(ledShadow), "LED readback");
    end
    endTest("LED writes");
  endtask

  task automatic hexWriteTest();
    startTest();
    repeat (20) begin
      writeBus(mmioPkg::addrHex, $urandom);
      checkRead(mmioPkg::addrHex, mmioPkg::word_t'(hexShadow), "hex readback");
      @(negedge clk);
      assert (hex == expectedDisplay(mmioPkg::word_t'(hexShadow)))
        else noteMismatch("hex digits stale after readback");
    end
    endTest("hex writes");
  endtask

  task automatic keyPortTest();
    startTest();
    // keys 0 and 2 pressed
    setKeys(4'b0101);
    checkRead(keyCtrl, 32'h1, "key status after press");
    checkRead(mmioPkg::addrKey, 32'h5, "key data");
    checkRead(keyCtrl, 32'h0, "key status after data read");
    // second change lands on an unread value
    setKeys(4'b0010);
    setKeys(4'b1000);
    checkRead(keyCtrl, 32'h3, "key status after two changes");
    // clear overrun, set ie
    writeBus(keyCtrl, 32'h8);
    checkRead(keyCtrl, 32'h9, "key status after control write");
    checkRead(mmioPkg::addrKey, 32'h8, "key data after overrun");
    checkRead(keyCtrl, 32'h8, "key status with ie only");
    writeBus(keyCtrl, 32'h2);
    checkRead(keyCtrl, 32'h0, "key status after ie cleared");
    setKeys(4'b0000);
    checkRead(mmioPkg::addrKey, 32'h0, "key data after release");
    endTest("key port");
  endtask

  task automatic switchPortTest();
    mmioPkg::switchData_t target;
    mmioPkg::word_t status;
    int polls;
    startTest();
    // glitch well inside the settle window
    setSwitches(10'h155);
    repeat (3) @(posedge clk);
    setSwitches('0);
    repeat (12) @(posedge clk);
    checkRead(swCtrl, '0, "switch status after glitch");
    checkRead(mmioPkg::addrSw, '0, "switch data after glitch");
    // nonzero so it differs from the idle value
    target = mmioPkg::switchData_t'($urandom) | 10'h001;
    setSwitches(target);
    polls = 0;
    status = '0;
    while (!status[mmioPkg::statReadyBit] && polls < pollLimit) begin
      readBus(swCtrl, status);
      polls++;
    end
    assert (status[mmioPkg::statReadyBit])
      else begin
        errorCount++;
        $display("Error: switch ready bit still clear after %0d status reads", polls);
      end
    checkRead(mmioPkg::addrSw, mmioPkg::word_t'(target), "switch data");
    checkRead(swCtrl, '0, "switch status after data read");
    endTest("switch port");
  endtask

  task automatic unmappedAccessTest();
    startTest();
    checkRead(32'hFFFF_F040, '0, "unmapped read");
    checkRead(32'hFFFF_F0A0, '0, "unmapped read");
    checkRead(32'h0000_0000, '0, "unmapped read");
    writeBus(32'hFFFF_F010, $urandom);
    writeBus(32'hFFFF_F0C0, $urandom);
    repeat (3) @(posedge clk);
    @(negedge clk);
    assert (ledr == ledShadow) else noteMismatch("ledr moved on unmapped write");
    assert (hex == expectedDisplay(mmioPkg::word_t'(hexShadow)))
      else noteMismatch("hex moved on unmapped write");
    checkRead(mmioPkg::addrLedr, mmioPkg::word_t'(ledShadow), "LED after unmapped write");
    checkRead(mmioPkg::addrHex, mmioPkg::word_t'(hexShadow), "hex after unmapped write");
    endTest("unmapped addresses");
  endtask

  initial begin
    void'($urandom(98));
    req = '0;
    key = 4'hF;
    sw = '0;
    ledShadow = '0;
    hexShadow = '0;
    errorCount = 0;
    testsRun = 0;
    testsFailed = 0;
    @(negedge reset);
    repeat (2) @(posedge clk);
    resetStateTest();
    ledWriteTest();
    hexWriteTest();
    keyPortTest();
    switchPortTest();
    unmappedAccessTest();
    // let pending display checks finish
    repeat (4) @(posedge clk);
    $display("tests run %0d, tests failed %0d, checks failed %0d",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog on clock cycles
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run still going after %0d cycles", cycleLimit);
    $display("Verification failed");
    $finish;
  end

endmodule

/* verilog.f */
verilog/mmioPkg.sv
verilog/ledPort.sv
verilog/hexPort.sv
verilog/inputPort.sv
verilog/mmioPeripherals.sv
tb/clockGen.sv
tb/mmioPeripheralsTb.sv

/* Bender.yml */
package:
  name: mmio_peripherals

sources:
  - files:
      - verilog/mmioPkg.sv
      - verilog/ledPort.sv
      - verilog/hexPort.sv
      - verilog/inputPort.sv
      - verilog/mmioPeripherals.sv

  - target: test
    files:
      - tb/clockGen.sv
      - tb/mmioPeripheralsTb.sv
